// ==== soc_io_pkg.sv ====
`default_nettype none

package soc_io_pkg;

  // Bus geometry
  localparam int DATA_W = 16;
  localparam int ADDR_W = 16;

  // One-hot address bits
  localparam int ADDR_GPIO_IN_BIT  = 8;
  localparam int ADDR_GPIO_OUT_BIT = 9;
  localparam int ADDR_GPIO_DIR_BIT = 10;
  localparam int ADDR_MISC_BIT     = 11;   // Enables the sub-selector
  localparam int ADDR_TICKS_BIT    = 14;
  localparam int ADDR_CYCLES_BIT   = 15;

  // Sub-selector field, address bits 7..4
  localparam int SUB_LSB = 4;
  localparam int SUB_MSB = 7;

  localparam logic [3:0] SUB_LEDS      = 4'd11;
  localparam logic [3:0] SUB_SDM_RED   = 4'd12;
  localparam logic [3:0] SUB_SDM_GREEN = 4'd13;
  localparam logic [3:0] SUB_SDM_BLUE  = 4'd14;

  // Write mode from address bits 1..0
  typedef enum logic [1:0] {
    OP_WRITE  = 2'd0,
    OP_CLEAR  = 2'd1,
    OP_SET    = 2'd2,
    OP_TOGGLE = 2'd3
  } io_op_e;

  // Register select inside one peripheral
  typedef enum logic [1:0] {
    REG_A = 2'd0,
    REG_B = 2'd1,
    REG_C = 2'd2,
    REG_D = 2'd3
  } io_reg_e;

  // Read-modify-write of a control register
  function automatic logic [DATA_W-1:0] apply_op(input io_op_e           op,
                                                 input logic [DATA_W-1:0] old_val,
                                                 input logic [DATA_W-1:0] wr_val);
    logic [DATA_W-1:0] res;
    case (op)
      OP_WRITE: res = wr_val;
      OP_CLEAR: res = old_val & ~wr_val;   // Clear bits
      OP_SET:   res = old_val | wr_val;    // Set bits
      default:  res = old_val ^ wr_val;    // Toggle bits
    endcase
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== io_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One decoded bus leg per peripheral
interface io_bus_if;
  import soc_io_pkg::*;

  logic              wr;          // Already qualified by the decoder
  io_op_e            op;          // Modify mode
  io_reg_e           sel;         // Register inside the peripheral
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;       // Register named by sel
  logic [DATA_W-1:0] rdata_alt;   // Second read port

  modport host (
    output wr, op, sel, wdata,
    input  rdata, rdata_alt
  );

  modport dev (
    input  wr, op, sel, wdata,
    output rdata, rdata_alt
  );

endinterface

`default_nettype wire

// ==== io_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_decode (
  input  logic                          clk,
  input  logic                          reset_button,
  input  logic                          io_wr,
  input  logic [soc_io_pkg::ADDR_W-1:0] io_addr,
  input  logic [soc_io_pkg::DATA_W-1:0] io_wdata,
  output logic [soc_io_pkg::DATA_W-1:0] io_rdata,
  io_bus_if.host                        gpio_bus,
  io_bus_if.host                        led_bus,
  io_bus_if.host                        timer_bus
);
  import soc_io_pkg::*;

  logic [3:0] sub;         // Sub-selector under the misc bit
  io_op_e     op;
  logic       hit_in;
  logic       hit_out;
  logic       hit_dir;
  logic       hit_gpio;    // Writable GPIO registers only
  logic       hit_led;
  logic       hit_ticks;
  logic       hit_cycles;
  io_reg_e    led_sel;
  io_reg_e    gpio_sel;

  assign sub = io_addr[SUB_MSB:SUB_LSB];
  assign op  = io_op_e'(io_addr[1:0]);

  assign hit_in     = io_addr[ADDR_GPIO_IN_BIT];
  assign hit_out    = io_addr[ADDR_GPIO_OUT_BIT];
  assign hit_dir    = io_addr[ADDR_GPIO_DIR_BIT];
  assign hit_gpio   = hit_out | hit_dir;
  assign hit_ticks  = io_addr[ADDR_TICKS_BIT];
  assign hit_cycles = io_addr[ADDR_CYCLES_BIT];

  // LED block answers to four sub codes only
  always_comb begin
    hit_led = io_addr[ADDR_MISC_BIT];
    case (sub)
      SUB_LEDS:      led_sel = REG_A;
      SUB_SDM_RED:   led_sel = REG_B;
      SUB_SDM_GREEN: led_sel = REG_C;
      SUB_SDM_BLUE:  led_sel = REG_D;
      default: begin
        led_sel = REG_A;
        hit_led = 1'b0;   // Dropped registers read as zero
      end
    endcase
  end

  // OUT and DIR together map to REG_D in the GPIO block
  always_comb begin
    case ({hit_dir, hit_out})
      2'b01:   gpio_sel = REG_B;
      2'b10:   gpio_sel = REG_C;
      2'b11:   gpio_sel = REG_D;
      default: gpio_sel = REG_A;
    endcase
  end

  // GPIO write steering
  assign gpio_bus.wr    = io_wr & hit_gpio;
  assign gpio_bus.op    = op;
  assign gpio_bus.sel   = gpio_sel;
  assign gpio_bus.wdata = io_wdata;

  // LED block loses to GPIO on a shared write
  assign led_bus.wr    = io_wr & hit_led & ~hit_gpio;
  assign led_bus.op    = op;
  assign led_bus.sel   = led_sel;
  assign led_bus.wdata = io_wdata;

  // Timer is lowest priority, cycles are read only
  assign timer_bus.wr    = io_wr & hit_ticks & ~hit_gpio & ~hit_led;
  assign timer_bus.op    = op;
  assign timer_bus.sel   = hit_ticks ? REG_A : REG_B;
  assign timer_bus.wdata = io_wdata;

  // Read data is the OR of every addressed register
  assign io_rdata = (hit_in     ? gpio_bus.rdata_alt  : '0) |
                    (hit_gpio   ? gpio_bus.rdata      : '0) |
                    (hit_led    ? led_bus.rdata       : '0) |
                    (hit_ticks  ? timer_bus.rdata     : '0) |
                    (hit_cycles ? timer_bus.rdata_alt : '0);

  // Steering needs a known address on every write
  a_addr_known : assert property (@(posedge clk) disable iff (reset_button)
    io_wr |-> !$isunknown(io_addr));

endmodule

`default_nettype wire

// ==== gpio_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_port #(
  parameter int GPIO_W = 8
) (
  input  logic              clk,
  input  logic              reset_button,
  io_bus_if.dev             bus,
  input  logic [GPIO_W-1:0] pin_in,
  output logic [GPIO_W-1:0] pin_out,
  output logic [GPIO_W-1:0] pin_oe
);
  import soc_io_pkg::*;

  // Selects: A input, B output, C direction, D output and direction
  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] dir_q;   // 1 drives the pin
  logic [GPIO_W-1:0] in_q;    // Pin sample
  logic              wr_out;
  logic              wr_dir;

  assign wr_out = bus.wr & ((bus.sel == REG_B) | (bus.sel == REG_D));
  assign wr_dir = bus.wr & ((bus.sel == REG_C) | (bus.sel == REG_D));

  always_ff @(posedge clk) begin
    if (reset_button) begin
      out_q <= '0;
      dir_q <= '0;
      in_q  <= '0;
    end else begin
      in_q <= pin_in;   // One cycle to read data
      if (wr_out)
        out_q <= GPIO_W'(apply_op(bus.op, DATA_W'(out_q), bus.wdata));
      if (wr_dir)
        dir_q <= GPIO_W'(apply_op(bus.op, DATA_W'(dir_q), bus.wdata));
    end
  end

  assign pin_out = out_q;
  assign pin_oe  = dir_q;

  always_comb begin
    case (bus.sel)
      REG_A:   bus.rdata = DATA_W'(in_q);
      REG_B:   bus.rdata = DATA_W'(out_q);
      REG_C:   bus.rdata = DATA_W'(dir_q);
      default: bus.rdata = DATA_W'(out_q | dir_q);   // Both bits addressed
    endcase
  end

  // Input register on its own port so it ORs with OUT or DIR
  assign bus.rdata_alt = DATA_W'(in_q);

  // Mode bits come straight from the address
  a_op_known : assert property (@(posedge clk) disable iff (reset_button)
    bus.wr |-> !$isunknown(bus.op));

endmodule

`default_nettype wire

// ==== led_dimmer.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_dimmer #(
  parameter int SDM_W = 16
) (
  input  logic       clk,
  input  logic       reset_button,
  io_bus_if.dev      bus,
  output logic [2:0] led_rgb        // 0 red, 1 green, 2 blue
);
  import soc_io_pkg::*;

  // Selects: A static LEDs, B red, C green, D blue
  logic [3:0]       leds_q;         // Bit 3 kept for software only
  logic [SDM_W-1:0] sdm_rd [3];     // Duty values for readback

  always_ff @(posedge clk) begin
    if (reset_button)
      leds_q <= '0;
    else if (bus.wr && bus.sel == REG_A)
      leds_q <= 4'(apply_op(bus.op, DATA_W'(leds_q), bus.wdata));
  end

  // One modulator per color
  for (genvar i = 0; i < 3; i++) begin : g_sdm
    logic [SDM_W-1:0] level_q;   // Duty setting
    logic [SDM_W-1:0] phase_q;   // Accumulator
    logic             carry_q;   // Pulse out

    always_ff @(posedge clk) begin
      if (reset_button) begin
        level_q <= '0;
        phase_q <= '0;
        carry_q <= 1'b0;
      end else begin
        {carry_q, phase_q} <= phase_q + level_q;   // Carry is next cycle's pulse
        if (bus.wr && bus.sel == io_reg_e'(i + 1))
          level_q <= bus.wdata[SDM_W-1:0];         // Plain write only
      end
    end

    assign sdm_rd[i]  = level_q;
    assign led_rgb[i] = leds_q[i] | carry_q;   // Static bit forces full on
  end

  always_comb begin
    case (bus.sel)
      REG_A:   bus.rdata = DATA_W'(leds_q);
      REG_B:   bus.rdata = DATA_W'(sdm_rd[0]);
      REG_C:   bus.rdata = DATA_W'(sdm_rd[1]);
      default: bus.rdata = DATA_W'(sdm_rd[2]);
    endcase
  end

  assign bus.rdata_alt = '0;   // No second read port here

endmodule

`default_nettype wire

// ==== tick_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tick_timer (
  input  logic  clk,
  input  logic  reset_button,
  io_bus_if.dev bus,
  output logic  irq
);
  import soc_io_pkg::*;

  // Selects: A ticks, B cycles
  logic [DATA_W-1:0] ticks_q;
  logic [DATA_W-1:0] cycles_q;
  logic [DATA_W:0]   ticks_inc;   // Carry out marks the wrap

  assign ticks_inc = {1'b0, ticks_q} + 1'b1;

  always_ff @(posedge clk) begin
    if (reset_button) begin
      ticks_q  <= '0;
      cycles_q <= '0;
      irq      <= 1'b0;
    end else begin
      if (bus.wr && bus.sel == REG_A)
        ticks_q <= bus.wdata;                // Load wins over count
      else
        ticks_q <= ticks_inc[DATA_W-1:0];
      irq      <= ticks_inc[DATA_W];          // Wrap seen even on a load
      cycles_q <= cycles_q + 1'b1;           // Free running
    end
  end

  always_comb begin
    case (bus.sel)
      REG_A:   bus.rdata = ticks_q;
      REG_B:   bus.rdata = cycles_q;
      default: bus.rdata = '0;
    endcase
  end

  assign bus.rdata_alt = cycles_q;   // Cycles readable next to ticks

  // Back to back pulses need a reload to all ones
  a_irq_spacing : assert property (@(posedge clk) disable iff (reset_button)
    irq ##1 irq |-> $past(bus.wr && bus.sel == REG_A && bus.wdata == '1, 2));

endmodule

`default_nettype wire

// ==== soc_io_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_io_top #(
  parameter int GPIO_W = 8,
  parameter int SDM_W  = 16
) (
  input  logic                          clk,
  input  logic                          reset_button,
  input  logic                          io_wr,
  input  logic [soc_io_pkg::ADDR_W-1:0] io_addr,
  input  logic [soc_io_pkg::DATA_W-1:0] io_wdata,
  output logic [soc_io_pkg::DATA_W-1:0] io_rdata,
  input  logic [GPIO_W-1:0]             gpio_in,
  output logic [GPIO_W-1:0]             gpio_out,
  output logic [GPIO_W-1:0]             gpio_oe,
  output logic [2:0]                    led_rgb,   // 0 red, 1 green, 2 blue
  output logic                          irq        // One cycle per tick wrap
);

  // One leg per peripheral
  io_bus_if bus_gpio ();
  io_bus_if bus_led ();
  io_bus_if bus_timer ();

  // Address map and read-back OR
  io_decode u_decode (
    .clk          (clk),
    .reset_button (reset_button),
    .io_wr        (io_wr),
    .io_addr      (io_addr),
    .io_wdata     (io_wdata),
    .io_rdata     (io_rdata),
    .gpio_bus     (bus_gpio.host),
    .led_bus      (bus_led.host),
    .timer_bus    (bus_timer.host)
  );

  gpio_port #(
    .GPIO_W (GPIO_W)
  ) u_gpio (
    .clk          (clk),
    .reset_button (reset_button),
    .bus          (bus_gpio.dev),
    .pin_in       (gpio_in),
    .pin_out      (gpio_out),
    .pin_oe       (gpio_oe)
  );

  // Static LEDs plus RGB modulators
  led_dimmer #(
    .SDM_W (SDM_W)
  ) u_led (
    .clk          (clk),
    .reset_button (reset_button),
    .bus          (bus_led.dev),
    .led_rgb      (led_rgb)
  );

  // Ticks and cycles
  tick_timer u_timer (
    .clk          (clk),
    .reset_button (reset_button),
    .bus          (bus_timer.dev),
    .irq          (irq)
  );

endmodule

`default_nettype wire

// ==== soc_io_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_io_tb;

  localparam int          GPIO_W   = 8;
  localparam int          SDM_W    = 16;
  localparam int          N_CYCLES = 4000;
  localparam int          TIMEOUT  = N_CYCLES + N_CYCLES / 2;   // Half again as margin
  localparam logic [31:0] SEED     = 32'h6e27;

  logic              clk;
  logic              reset_button;
  logic              io_wr;
  logic [15:0]       io_addr;
  logic [15:0]       io_wdata;
  logic [15:0]       io_rdata;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;
  logic [2:0]        led_rgb;
  logic              irq;

  // Reference model state, mirrors the registers after each edge
  logic [GPIO_W-1:0] m_out;
  logic [GPIO_W-1:0] m_dir;
  logic [GPIO_W-1:0] m_in;     // Pin sample
  logic [3:0]        m_leds;
  logic [SDM_W-1:0]  m_level [3];
  logic [SDM_W-1:0]  m_phase [3];
  logic [2:0]        m_carry;
  logic [15:0]       m_ticks;
  logic [15:0]       m_cycles;
  logic              m_irq;

  int                tick_count;   // Watchdog
  int                cyc;
  int unsigned       seed_ret;

  soc_io_top #(
    .GPIO_W (GPIO_W),
    .SDM_W  (SDM_W)
  ) dut0 (
    .clk          (clk),
    .reset_button (reset_button),
    .io_wr        (io_wr),
    .io_addr      (io_addr),
    .io_wdata     (io_wdata),
    .io_rdata     (io_rdata),
    .gpio_in      (gpio_in),
    .gpio_out     (gpio_out),
    .gpio_oe      (gpio_oe),
    .led_rgb      (led_rgb),
    .irq          (irq)
  );

  always #2 clk = ~clk;   // 4 ns period

  // Ends a stuck run
  always @(posedge clk) begin
    tick_count <= tick_count + 1;
    if (tick_count >= TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Test failed");
      $fatal(1, "Simulation timed out");
    end
  end

  // Write modes from address bits 1..0
  function automatic logic [15:0] modify(input logic [1:0]  mode,
                                         input logic [15:0] old_v,
                                         input logic [15:0] val);
    case (mode)
      2'd0:    modify = val;            // Plain write
      2'd1:    modify = old_v & ~val;   // Clear
      2'd2:    modify = old_v | val;    // Set
      default: modify = old_v ^ val;    // Toggle
    endcase
  endfunction

  // Misc bit plus one of the four live sub codes
  function automatic logic led_hit(input logic [15:0] a);
    return a[11] && (a[7:4] >= 4'd11) && (a[7:4] <= 4'd14);
  endfunction

  // OR of every addressed register
  function automatic logic [15:0] model_read(input logic [15:0] a);
    logic [15:0] r;
    r = '0;
    if (a[8])
      r = r | 16'(m_in);
    if (a[9])
      r = r | 16'(m_out);
    if (a[10])
      r = r | 16'(m_dir);
    if (a[11]) begin
      case (a[7:4])
        4'd11:   r = r | 16'(m_leds);
        4'd12:   r = r | m_level[0];
        4'd13:   r = r | m_level[1];
        4'd14:   r = r | m_level[2];
        default: r = r;   // Dropped registers
      endcase
    end
    if (a[14])
      r = r | m_ticks;
    if (a[15])
      r = r | m_cycles;
    return r;
  endfunction

  task automatic check_value(input string       name,
                             input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "Output mismatch on %s", name);
    end
  endtask

  // Applies the inputs seen at this edge, old state on every right side
  task automatic model_step();
    logic           gpio_hit;
    logic           led_wr;
    logic [1:0]     mode;
    logic [SDM_W:0] sum;
    gpio_hit = io_addr[9] | io_addr[10];
    led_wr   = io_wr && led_hit(io_addr) && !gpio_hit;   // GPIO wins a shared write
    mode     = io_addr[1:0];
    if (reset_button) begin
      m_out    = '0;
      m_dir    = '0;
      m_in     = '0;
      m_leds   = '0;
      m_carry  = '0;
      m_ticks  = '0;
      m_cycles = '0;
      m_irq    = 1'b0;
      for (int i = 0; i < 3; i++) begin
        m_level[i] = '0;
        m_phase[i] = '0;
      end
    end else begin
      m_irq = (m_ticks == 16'hffff);   // Wrap at this edge
      if (io_wr && io_addr[14] && !gpio_hit && !led_hit(io_addr))
        m_ticks = io_wdata;
      else
        m_ticks = m_ticks + 16'd1;
      m_cycles = m_cycles + 16'd1;
      m_in     = gpio_in;
      if (io_wr && io_addr[9])
        m_out = GPIO_W'(modify(mode, 16'(m_out), io_wdata));
      if (io_wr && io_addr[10])
        m_dir = GPIO_W'(modify(mode, 16'(m_dir), io_wdata));
      for (int i = 0; i < 3; i++) begin
        sum        = {1'b0, m_phase[i]} + {1'b0, m_level[i]};
        m_carry[i] = sum[SDM_W];   // Old level drives this step
        m_phase[i] = sum[SDM_W-1:0];
      end
      if (led_wr) begin
        case (io_addr[7:4])
          4'd11:   m_leds = 4'(modify(mode, 16'(m_leds), io_wdata));
          4'd12:   m_level[0] = io_wdata;
          4'd13:   m_level[1] = io_wdata;
          default: m_level[2] = io_wdata;
        endcase
      end
    end
  endtask

  // Sampled mid cycle, away from the edge
  task automatic check_outputs();
    check_value("io_rdata", io_rdata, model_read(io_addr));
    check_value("gpio_out", gpio_out, m_out);
    check_value("gpio_oe", gpio_oe, m_dir);
    check_value("led_rgb", led_rgb, m_leds[2:0] | m_carry);
    check_value("irq", irq, m_irq);
  endtask

  // Stimulus focus changes with the cycle number
  task automatic drive_inputs(input int n);
    logic [15:0] addr;
    logic        wr;
    logic [15:0] data;
    addr = '0;
    wr   = ($urandom % 3) == 0;
    data = 16'($urandom);
    if (n < 800) begin
      addr[10:8] = 3'($urandom % 7 + 1);   // IN, OUT, DIR in any mix
      addr[1:0]  = 2'($urandom);
    end else if (n < 1600) begin
      addr[11]   = 1'b1;
      if (($urandom % 8) == 0)
        addr[7:4] = 4'($urandom);          // Sometimes unmapped
      else
        addr[7:4] = 4'(11 + $urandom % 4);
      addr[1:0]  = 2'($urandom);
    end else if (n < 2400) begin
      addr[15:14] = 2'($urandom % 3 + 1);  // Ticks, cycles or both
      wr          = ($urandom % 6) == 0;
      data        = 16'hffff - 16'($urandom % 6);   // Close to the wrap
    end else begin
      addr = 16'($urandom);                // Many one-hot bits at once
      wr   = ($urandom % 4) == 0;
    end
    io_wr    <= wr;
    io_addr  <= addr;
    io_wdata <= data;
    gpio_in  <= GPIO_W'($urandom);
  endtask

  initial begin
    clk          = 1'b0;
    reset_button = 1'b1;
    io_wr        = 1'b0;
    io_addr      = '0;
    io_wdata     = '0;
    gpio_in      = '0;
    tick_count   = 0;
    seed_ret     = $urandom(SEED);

    for (cyc = 0; cyc < N_CYCLES; cyc++) begin
      @(posedge clk);
      model_step();
      if (cyc == 1)
        reset_button <= 1'b0;   // Edges 0 and 1 see reset
      if (cyc >= 1)
        drive_inputs(cyc);
      @(negedge clk);
      check_outputs();
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== soc_io.f ====
soc_io_pkg.sv
io_bus_if.sv
io_decode.sv
gpio_port.sv
led_dimmer.sv
tick_timer.sv
soc_io_top.sv
soc_io_tb.sv
